/* include/rv_encode.svh */
`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

// instruction word builders for the supported subset
function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
endfunction

// op-imm and lw
function automatic logic [31:0] i_type_word(input isa_pkg::opcode_e op, input logic [2:0] f3,
                                            input logic [4:0] rd, rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sw_word(input logic [4:0] rs1, rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, isa_pkg::F3_SW, imm[4:0], isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                            input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], isa_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, isa_pkg::OPC_LUI};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, isa_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] csrrw_word(input logic [4:0] rd, rs1);
    return {isa_pkg::CSR_TOHOST, rs1, isa_pkg::F3_CSRRW, rd, isa_pkg::OPC_SYSTEM};
endfunction

`endif

/* bench/core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module core_tb;

    localparam logic [17:0] R_F3 = {isa_pkg::F3_SLT, isa_pkg::F3_XOR, isa_pkg::F3_OR,
                                    isa_pkg::F3_AND, isa_pkg::F3_ADD_SUB,
                                    isa_pkg::F3_ADD_SUB};
    localparam logic [11:0] I_F3 = {isa_pkg::F3_XOR, isa_pkg::F3_OR, isa_pkg::F3_AND,
                                    isa_pkg::F3_ADD_SUB};

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        imem_we;
    logic [9:0]  imem_addr;
    logic [31:0] imem_data;
    logic [31:0] csr;
    logic        csr_wr;

    logic [31:0] rf [32];          // architectural register model
    logic [31:0] mem_model [1024];
    logic [31:0] prog [$];
    logic [31:0] exp_q [$];
    logic [31:0] expected;
    bit          live = 1'b1;      // low while building instructions that get skipped
    bit          built = 1'b0;
    int          exp_total;
    int          writes_seen = 0;
    int          value_cnt = 0;
    int          extra_cnt = 0;
    int          missing_cnt = 0;
    int          early_cnt = 0;
    int          timeout_cnt = 0;

    `include "rv_encode.svh"

    riscv_core uut (
        .clk(clk), .rst_n_i(rst_n), .run_i(run),
        .imem_we_i(imem_we), .imem_addr_i(imem_addr), .imem_data_i(imem_data),
        .csr_o(csr), .csr_wr_o(csr_wr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // integer results as the ISA defines them
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, b);
        case (f3)
            isa_pkg::F3_ADD_SUB: return sub ? a - b : a + b;
            isa_pkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::F3_XOR:     return a ^ b;
            isa_pkg::F3_OR:      return a | b;
            isa_pkg::F3_AND:     return a & b;
            default:             return 'x;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] val);
        if (live && rd != 5'd0) begin
            rf[rd] = val;
        end
    endtask

    task automatic alu_r(input logic [2:0] f3, input logic sub, input logic [4:0] rd, rs1, rs2);
        emit(r_type_word(sub ? isa_pkg::F7_SUB : isa_pkg::F7_BASE, f3, rd, rs1, rs2));
        set_reg(rd, alu_model(f3, sub, rf[rs1], rf[rs2]));
    endtask

    task automatic alu_i(input logic [2:0] f3, input logic [4:0] rd, rs1, input logic [11:0] imm);
        emit(i_type_word(isa_pkg::OPC_OP_IMM, f3, rd, rs1, imm));
        set_reg(rd, alu_model(f3, 1'b0, rf[rs1], sext12(imm)));
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        emit(lui_word(rd, imm));
        set_reg(rd, {imm, 12'b0});
    endtask

    task automatic store_word(input logic [4:0] rs2, rs1, input logic [11:0] off);
        logic [31:0] addr;
        addr = rf[rs1] + sext12(off);
        emit(sw_word(rs1, rs2, off));
        if (live) begin
            mem_model[addr[11:2]] = rf[rs2];
        end
    endtask

    task automatic load_word(input logic [4:0] rd, rs1, input logic [11:0] off);
        logic [31:0] addr;
        addr = rf[rs1] + sext12(off);
        emit(i_type_word(isa_pkg::OPC_LOAD, isa_pkg::F3_LW, rd, rs1, off));
        set_reg(rd, mem_model[addr[11:2]]);
    endtask

    // rs1 goes to the csr, rd reads back zero
    task automatic csr_write(input logic [4:0] rd, rs1);
        emit(csrrw_word(rd, rs1));
        if (live) begin
            exp_q.push_back(rf[rs1]);
        end
        set_reg(rd, 32'd0);
    endtask

    // branch over an increment of x31 and its csr write
    task automatic branch_over(input logic [2:0] f3, input logic [4:0] rs1, rs2);
        logic taken;
        taken = (rf[rs1] == rf[rs2]) != (f3 == isa_pkg::F3_BNE);
        emit(branch_word(f3, rs1, rs2, 13'd12));
        live = !taken;
        alu_i(isa_pkg::F3_ADD_SUB, 5'd31, 5'd31, 12'h001);
        csr_write(5'd0, 5'd31);
        live = 1'b1;
    endtask

    task automatic jump_link(input logic [4:0] rd);
        logic [31:0] link;
        link = prog.size() * 4 + 4;
        emit(jal_word(rd, 21'd12));
        set_reg(rd, link);
        live = 1'b0;              // never executed
        alu_i(isa_pkg::F3_ADD_SUB, 5'd31, 5'd31, 12'h001);
        csr_write(5'd0, 5'd31);
        live = 1'b1;
    endtask

    task automatic build_program();
        logic [4:0] ra;
        logic [4:0] rb;
        for (int i = 0; i < 32; i++) begin
            rf[i] = 32'd0;
        end
        for (int r = 1; r <= 8; r++) begin
            load_upper(r[4:0], 20'($urandom()));
            alu_i(isa_pkg::F3_ADD_SUB, r[4:0], r[4:0], 12'($urandom()));
        end
        for (int k = 0; k < 6; k++) begin
            ra = 5'(1 + $urandom() % 8);
            rb = 5'(1 + $urandom() % 8);
            alu_r(R_F3[3*k +: 3], k == 1, 5'(9 + k), ra, rb);  // k 1 is sub
            csr_write(5'd0, 5'(9 + k));
        end
        for (int k = 0; k < 4; k++) begin
            alu_i(I_F3[3*k +: 3], 5'(15 + k), 5'(1 + $urandom() % 8), 12'($urandom()));
            csr_write(5'd0, 5'(15 + k));
        end
        // dependency distances one to three
        alu_i(isa_pkg::F3_ADD_SUB, 5'd20, 5'd1, 12'($urandom()));
        alu_r(isa_pkg::F3_ADD_SUB, 1'b0, 5'd21, 5'd20, 5'd2);
        alu_i(isa_pkg::F3_XOR, 5'd22, 5'd3, 12'($urandom()));
        alu_r(isa_pkg::F3_ADD_SUB, 1'b1, 5'd23, 5'd20, 5'd22);
        alu_r(isa_pkg::F3_ADD_SUB, 1'b0, 5'd24, 5'd21, 5'd23);
        csr_write(5'd0, 5'd24);
        csr_write(5'd0, 5'd21);
        // store, load back, use at once
        alu_i(isa_pkg::F3_ADD_SUB, 5'd25, 5'd0, 12'h100);
        store_word(5'd24, 5'd25, 12'h008);
        load_word(5'd26, 5'd25, 12'h008);
        alu_r(isa_pkg::F3_ADD_SUB, 1'b0, 5'd27, 5'd26, 5'd1);
        csr_write(5'd0, 5'd27);
        csr_write(5'd0, 5'd26);
        alu_i(isa_pkg::F3_ADD_SUB, 5'd31, 5'd0, 12'($urandom()));
        branch_over(isa_pkg::F3_BEQ, 5'd9, 5'd9);
        branch_over(isa_pkg::F3_BNE, 5'd9, 5'd9);
        branch_over(isa_pkg::F3_BEQ, 5'd1, 5'd2);
        branch_over(isa_pkg::F3_BNE, 5'd1, 5'd2);
        csr_write(5'd0, 5'd31);
        jump_link(5'd10);
        csr_write(5'd0, 5'd10);
        // x0 stays zero, csr rd reads zero
        alu_i(isa_pkg::F3_ADD_SUB, 5'd0, 5'd1, 12'($urandom()));
        alu_r(isa_pkg::F3_ADD_SUB, 1'b0, 5'd0, 5'd2, 5'd3);
        csr_write(5'd0, 5'd0);
        csr_write(5'd12, 5'd1);
        csr_write(5'd0, 5'd12);
        emit(jal_word(5'd0, 21'd0));  // park here
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #2;
            imem_we   = 1'b1;
            imem_addr = i[9:0];
            imem_data = prog[i];
        end
        @(posedge clk);
        #2;
        imem_we = 1'b0;
    endtask

    task automatic close_run();
        int errors;
        if (exp_q.size() != 0) begin
            missing_cnt = exp_q.size();
            $display("%0d expected CSR writes never arrived", missing_cnt);
        end
        errors = value_cnt + extra_cnt + missing_cnt + early_cnt + timeout_cnt;
        $display("errors %0d: wrong value %0d, unexpected %0d, missing %0d, early %0d, timeout %0d",
                 errors, value_cnt, extra_cnt, missing_cnt, early_cnt, timeout_cnt);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // csr outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!csr_wr) else begin
                early_cnt++;
                $display("csr_wr_o went high while reset was asserted");
            end
        end
        if (writes_seen == 0 && !csr_wr) begin
            assert (csr == 32'd0) else begin
                early_cnt++;
                $display("FAIL at %0t: csr_o is %h before any CSR write", $time, csr);
            end
        end
        if (csr_wr) begin
            writes_seen++;
            if (exp_q.size() == 0) begin
                extra_cnt++;
                $display("CSR write of %h arrived when no more writes were expected", csr);
            end else begin
                expected = exp_q.pop_front();
                assert (csr == expected) else begin
                    value_cnt++;
                    $display("FAIL at %0t: csr_o %h, expected %h", $time, csr, expected);
                end
            end
        end
    end

    initial begin
        int unsigned limit;
        wait (built);
        limit = 16 + prog.size() + 8 * exp_total + 200;
        repeat (limit) @(posedge clk);
        timeout_cnt = 1;
        $display("run stopped by the watchdog after %0d cycles, %0d CSR writes outstanding",
                 limit, exp_q.size());
        close_run();
    end

    initial begin
        int unsigned seed_ret;
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        seed_ret  = $urandom(13093);
        build_program();
        exp_total = exp_q.size();
        built     = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        load_program();
        @(posedge clk);
        #2;
        run = 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (40) @(posedge clk);  // room for stray late writes
        close_run();
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/data_memory.sv
source/writeback_stage.sv
source/riscv_core.sv
bench/core_tb.sv

/* source/data_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module data_memory #(
    parameter int DMEM_AWIDTH = 10
) (
    input  wire logic                clk,
    input  wire pipe_pkg::mem_req_t  req_i,
    output logic [isa_pkg::XLEN-1:0] rdata_o
);

    logic [isa_pkg::XLEN-1:0] mem [2**DMEM_AWIDTH];
    logic [DMEM_AWIDTH-1:0]   word_addr;

    assign word_addr = req_i.addr[DMEM_AWIDTH+1:2];  // byte offset dropped

    // read data lands in the writeback cycle
    always_ff @(posedge clk) begin
        if (req_i.we) begin
            mem[word_addr] <= req_i.wdata;
        end
        rdata_o <= mem[word_addr];
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic                      clk,
    input  wire logic                      rst_n_i,
    input  wire logic                      flush_i,
    input  wire pipe_pkg::fetch_t          fetch_i,
    output logic [isa_pkg::REG_W-1:0]      ra1_o,
    output logic [isa_pkg::REG_W-1:0]      ra2_o,
    input  wire logic [isa_pkg::XLEN-1:0]  rd1_i,
    input  wire logic [isa_pkg::XLEN-1:0]  rd2_i,
    output pipe_pkg::dec_ex_t              dec_o
);

    logic [isa_pkg::XLEN-1:0] inst;
    logic [2:0]               funct3;
    isa_pkg::opcode_e         opcode;
    pipe_pkg::dec_ex_t        dec;

    function automatic pipe_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub);
        case (f3)
            isa_pkg::F3_ADD_SUB: begin
                if (sub) begin
                    return pipe_pkg::ALU_SUB;
                end
                return pipe_pkg::ALU_ADD;
            end
            isa_pkg::F3_SLT: return pipe_pkg::ALU_SLT;
            isa_pkg::F3_XOR: return pipe_pkg::ALU_XOR;
            isa_pkg::F3_OR:  return pipe_pkg::ALU_OR;
            isa_pkg::F3_AND: return pipe_pkg::ALU_AND;
            default:         return pipe_pkg::ALU_ADD;
        endcase
    endfunction

    assign inst   = fetch_i.inst;
    assign funct3 = inst[14:12];
    assign opcode = isa_pkg::opcode_e'(inst[6:0]);
    assign ra1_o  = inst[19:15];
    assign ra2_o  = inst[24:20];

    always_comb begin
        dec         = '0;
        dec.valid   = fetch_i.valid;
        dec.pc      = fetch_i.pc;
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.rd      = inst[11:7];
        dec.rs1_val = rd1_i;
        dec.rs2_val = rd2_i;
        dec.alu_op  = pipe_pkg::ALU_ADD;
        dec.wb_sel  = pipe_pkg::WB_ALU;
        case (opcode)
            isa_pkg::OPC_OP: begin
                dec.alu_op    = alu_from_f3(funct3, inst[31:25] == isa_pkg::F7_SUB);
                dec.reg_write = 1'b1;
            end
            isa_pkg::OPC_OP_IMM: begin
                dec.alu_op    = alu_from_f3(funct3, 1'b0);
                dec.use_imm   = 1'b1;
                dec.imm       = {{20{inst[31]}}, inst[31:20]};
                dec.reg_write = 1'b1;
            end
            isa_pkg::OPC_LUI: begin
                dec.alu_op    = pipe_pkg::ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.imm       = {inst[31:12], 12'b0};
                dec.reg_write = 1'b1;
            end
            isa_pkg::OPC_LOAD: begin
                dec.valid     = fetch_i.valid && funct3 == isa_pkg::F3_LW;
                dec.use_imm   = 1'b1;
                dec.imm       = {{20{inst[31]}}, inst[31:20]};
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_sel    = pipe_pkg::WB_MEM;
            end
            isa_pkg::OPC_STORE: begin
                dec.valid     = fetch_i.valid && funct3 == isa_pkg::F3_SW;
                dec.use_imm   = 1'b1;
                dec.imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dec.mem_write = 1'b1;
            end
            isa_pkg::OPC_BRANCH: begin
                dec.valid     = fetch_i.valid &&
                                (funct3 == isa_pkg::F3_BEQ || funct3 == isa_pkg::F3_BNE);
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3 == isa_pkg::F3_BNE;
                dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            isa_pkg::OPC_JAL: begin
                dec.is_jal    = 1'b1;
                dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                dec.reg_write = 1'b1;
                dec.wb_sel    = pipe_pkg::WB_LINK;
            end
            isa_pkg::OPC_SYSTEM: begin
                // csrrw to tohost only, rd gets the zero imm
                dec.valid     = fetch_i.valid && funct3 == isa_pkg::F3_CSRRW &&
                                inst[31:20] == isa_pkg::CSR_TOHOST;
                dec.csr_write = 1'b1;
                dec.alu_op    = pipe_pkg::ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: dec.valid = 1'b0;  // unsupported opcode
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_o <= '0;
        end else begin
            dec_o       <= dec;
            dec_o.valid <= dec.valid && !flush_i;  // killed behind a taken branch
        end
    end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage #(
    parameter int DMEM_AWIDTH = 10
) (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire pipe_pkg::dec_ex_t   dec_i,
    input  wire pipe_pkg::reg_wr_t   wb_fwd_i,
    output pipe_pkg::mem_req_t       mem_o,
    output logic                     redirect_o,
    output logic [isa_pkg::XLEN-1:0] target_o,
    output logic [isa_pkg::XLEN-1:0] csr_o,
    output logic                     csr_wr_o,
    output pipe_pkg::ex_wb_t         ex_o
);

    logic [isa_pkg::XLEN-1:0] op_a;
    logic [isa_pkg::XLEN-1:0] op_b_reg;  // rs2 after forwarding
    logic [isa_pkg::XLEN-1:0] op_b;
    logic [isa_pkg::XLEN-1:0] alu_res;
    logic                     taken;

    function automatic logic [isa_pkg::XLEN-1:0] fwd(
        input logic [isa_pkg::REG_W-1:0] idx,
        input logic [isa_pkg::XLEN-1:0]  val,
        input pipe_pkg::reg_wr_t         wb
    );
        if (wb.we && wb.addr == idx && idx != '0) begin
            return wb.data;
        end
        return val;
    endfunction

    assign op_a     = fwd(dec_i.rs1, dec_i.rs1_val, wb_fwd_i);
    assign op_b_reg = fwd(dec_i.rs2, dec_i.rs2_val, wb_fwd_i);
    assign op_b     = dec_i.use_imm ? dec_i.imm : op_b_reg;

    always_comb begin
        case (dec_i.alu_op)
            pipe_pkg::ALU_ADD:    alu_res = op_a + op_b;
            pipe_pkg::ALU_SUB:    alu_res = op_a - op_b;
            pipe_pkg::ALU_AND:    alu_res = op_a & op_b;
            pipe_pkg::ALU_OR:     alu_res = op_a | op_b;
            pipe_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            pipe_pkg::ALU_SLT:
                alu_res = {{(isa_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            pipe_pkg::ALU_PASS_B: alu_res = op_b;  // lui and csrrw
            default:              alu_res = '0;
        endcase
    end

    // branches compare the two registers, never the imm
    assign taken      = dec_i.is_branch && ((op_a == op_b_reg) != dec_i.branch_ne);
    assign redirect_o = dec_i.valid && (taken || dec_i.is_jal);
    assign target_o   = dec_i.pc + dec_i.imm;

    always_comb begin
        mem_o.addr = '0;  // address idles when there is no access
        if (dec_i.mem_read || dec_i.mem_write) begin
            mem_o.addr[DMEM_AWIDTH+1:0] = alu_res[DMEM_AWIDTH+1:0];
        end
        mem_o.wdata = op_b_reg;
        mem_o.we    = dec_i.valid && dec_i.mem_write;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o     <= '0;
            csr_o    <= '0;
            csr_wr_o <= 1'b0;
        end else begin
            ex_o.valid      <= dec_i.valid;
            ex_o.rd         <= dec_i.rd;
            ex_o.reg_write  <= dec_i.reg_write;
            ex_o.wb_sel     <= dec_i.wb_sel;
            ex_o.alu_result <= alu_res;
            ex_o.link       <= dec_i.pc + 32'd4;
            csr_wr_o        <= dec_i.valid && dec_i.csr_write;
            if (dec_i.valid && dec_i.csr_write) begin
                csr_o <= op_a;
            end
        end
    end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] RESET_PC    = 32'h0,
    parameter int          IMEM_AWIDTH = 10
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n_i,
    input  wire logic                     run_i,
    input  wire logic                     redirect_i,
    input  wire logic [isa_pkg::XLEN-1:0] target_i,
    input  wire logic                     imem_we_i,
    input  wire logic [IMEM_AWIDTH-1:0]   imem_addr_i,
    input  wire logic [isa_pkg::XLEN-1:0] imem_data_i,
    output pipe_pkg::fetch_t              fetch_o
);

    logic [isa_pkg::XLEN-1:0] imem [2**IMEM_AWIDTH];
    logic [isa_pkg::XLEN-1:0] pc_q;     // pc of the word in inst_q
    logic [isa_pkg::XLEN-1:0] inst_q;
    logic [isa_pkg::XLEN-1:0] next_pc;
    logic                     valid_q;

    // an invalid slot refetches its own pc, so the target is read after a redirect
    always_comb begin
        if (redirect_i) begin
            next_pc = target_i;
        end else if (valid_q) begin
            next_pc = pc_q + 32'd4;
        end else begin
            next_pc = pc_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= run_i ? next_pc : RESET_PC;  // halted pc parks at reset
            valid_q <= run_i && !redirect_i;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_we_i && !run_i) begin
            imem[imem_addr_i] <= imem_data_i;  // program load only while halted
        end
        inst_q <= imem[next_pc[IMEM_AWIDTH+1:2]];
    end

    always_comb begin
        fetch_o.valid = valid_q;
        fetch_o.pc    = pc_q;
        fetch_o.inst  = inst_q;
    end

endmodule

`default_nettype wire

/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int XLEN  = 32;  // word width
    localparam int REG_W = 5;   // register index width

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LW    = 3'b010;  // word loads and stores only
    localparam logic [2:0] F3_SW    = 3'b010;
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;
    localparam logic [2:0] F3_CSRRW = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;  // sub in R-type

    // the one writable csr, mirrored on the csr output port
    localparam logic [11:0] CSR_TOHOST = 12'h51e;

endpackage

`default_nettype wire

/* source/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

    typedef struct packed {
        logic                      valid;
        logic [isa_pkg::XLEN-1:0]  pc;
        logic [isa_pkg::XLEN-1:0]  inst;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        logic [isa_pkg::XLEN-1:0]  pc;
        logic [isa_pkg::REG_W-1:0] rs1;
        logic [isa_pkg::REG_W-1:0] rs2;
        logic [isa_pkg::XLEN-1:0]  rs1_val;
        logic [isa_pkg::XLEN-1:0]  rs2_val;
        logic [isa_pkg::XLEN-1:0]  imm;
        logic [isa_pkg::REG_W-1:0] rd;
        alu_op_e                   alu_op;
        logic                      use_imm;    // imm replaces rs2 as alu operand b
        logic                      is_branch;
        logic                      branch_ne;
        logic                      is_jal;
        logic                      mem_read;
        logic                      mem_write;
        logic                      csr_write;
        logic                      reg_write;
        wb_sel_e                   wb_sel;
    } dec_ex_t;

    typedef struct packed {
        logic                      valid;
        logic [isa_pkg::REG_W-1:0] rd;
        logic                      reg_write;
        wb_sel_e                   wb_sel;
        logic [isa_pkg::XLEN-1:0]  alu_result;
        logic [isa_pkg::XLEN-1:0]  link;       // pc + 4 of a jal
    } ex_wb_t;

    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]  addr;
        logic [isa_pkg::XLEN-1:0]  wdata;
        logic                      we;
    } mem_req_t;

    typedef struct packed {
        logic                      we;
        logic [isa_pkg::REG_W-1:0] addr;
        logic [isa_pkg::XLEN-1:0]  data;
    } reg_wr_t;

endpackage

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire logic                      clk,
    input  wire logic                      rst_n_i,
    input  wire pipe_pkg::reg_wr_t         wr_i,
    input  wire logic [isa_pkg::REG_W-1:0] ra1_i,
    input  wire logic [isa_pkg::REG_W-1:0] ra2_i,
    output logic [isa_pkg::XLEN-1:0]       rd1_o,
    output logic [isa_pkg::XLEN-1:0]       rd2_o
);

    logic [isa_pkg::XLEN-1:0] regs [1:31];  // x0 has no storage

    // x0 reads zero, a write to the same index passes straight through
    function automatic logic [isa_pkg::XLEN-1:0] read_port(
        input logic [isa_pkg::REG_W-1:0] ra,
        input pipe_pkg::reg_wr_t         wr
    );
        if (ra == '0) begin
            return '0;
        end
        if (wr.we && wr.addr == ra) begin
            return wr.data;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    always_comb begin
        rd1_o = read_port(ra1_i, wr_i);
        rd2_o = read_port(ra2_i, wr_i);
    end

endmodule

`default_nettype wire

/* source/riscv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_core #(
    parameter logic [31:0] RESET_PC    = 32'h0,
    parameter int          IMEM_AWIDTH = 10,
    parameter int          DMEM_AWIDTH = 10
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n_i,
    input  wire logic                     run_i,
    input  wire logic                     imem_we_i,
    input  wire logic [IMEM_AWIDTH-1:0]   imem_addr_i,
    input  wire logic [isa_pkg::XLEN-1:0] imem_data_i,
    output logic [isa_pkg::XLEN-1:0]      csr_o,
    output logic                          csr_wr_o
);

    pipe_pkg::fetch_t         fetch;
    pipe_pkg::dec_ex_t        dec_ex;
    pipe_pkg::ex_wb_t         ex_wb;
    pipe_pkg::mem_req_t       mem_req;
    pipe_pkg::reg_wr_t        reg_wr;     // also the forwarding path
    logic [isa_pkg::REG_W-1:0] ra1, ra2;
    logic [isa_pkg::XLEN-1:0] rd1, rd2;
    logic [isa_pkg::XLEN-1:0] dmem_rdata;
    logic [isa_pkg::XLEN-1:0] target;
    logic                     redirect;

    fetch_stage #(.RESET_PC(RESET_PC), .IMEM_AWIDTH(IMEM_AWIDTH)) u_fetch (
        .clk(clk), .rst_n_i(rst_n_i), .run_i(run_i),
        .redirect_i(redirect), .target_i(target),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
        .fetch_o(fetch)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(redirect), .fetch_i(fetch),
        .ra1_o(ra1), .ra2_o(ra2), .rd1_i(rd1), .rd2_i(rd2), .dec_o(dec_ex)
    );

    register_file u_regs (
        .clk(clk), .rst_n_i(rst_n_i), .wr_i(reg_wr),
        .ra1_i(ra1), .ra2_i(ra2), .rd1_o(rd1), .rd2_o(rd2)
    );

    execute_stage #(.DMEM_AWIDTH(DMEM_AWIDTH)) u_execute (
        .clk(clk), .rst_n_i(rst_n_i), .dec_i(dec_ex), .wb_fwd_i(reg_wr),
        .mem_o(mem_req), .redirect_o(redirect), .target_o(target),
        .csr_o(csr_o), .csr_wr_o(csr_wr_o), .ex_o(ex_wb)
    );

    data_memory #(.DMEM_AWIDTH(DMEM_AWIDTH)) u_dmem (
        .clk(clk), .req_i(mem_req), .rdata_o(dmem_rdata)
    );

    writeback_stage u_writeback (
        .ex_i(ex_wb), .mem_rdata_i(dmem_rdata), .wr_o(reg_wr)
    );

endmodule

`default_nettype wire

/* source/writeback_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
    input  wire pipe_pkg::ex_wb_t         ex_i,
    input  wire logic [isa_pkg::XLEN-1:0] mem_rdata_i,
    output pipe_pkg::reg_wr_t             wr_o
);

    always_comb begin
        wr_o.we   = ex_i.valid && ex_i.reg_write && ex_i.rd != '0;  // x0 writes dropped
        wr_o.addr = ex_i.rd;
        case (ex_i.wb_sel)
            pipe_pkg::WB_ALU:  wr_o.data = ex_i.alu_result;
            pipe_pkg::WB_MEM:  wr_o.data = mem_rdata_i;
            pipe_pkg::WB_LINK: wr_o.data = ex_i.link;
            default:           wr_o.data = '0;
        endcase
    end

endmodule

`default_nettype wire
